/* memoryPkg.sv */
`default_nettype none

package memoryPkg;

	localparam int boardSide = 4; // Rows and columns of the board.
	localparam int coordWidth = 2;
	localparam int valueWidth = 3;
	localparam int pairCount = 8; // All pairs found ends the game.
	localparam int scoreWidth = 4;

	// Card values in row-major order, so the index is posY * boardSide + posX.
	// Every value from 0 to 7 shows up on exactly two cards.
	localparam logic [valueWidth-1:0] cardLayout [boardSide*boardSide] = '{
		3'd0, 3'd3, 3'd7, 3'd2,
		3'd6, 3'd4, 3'd1, 3'd7,
		3'd1, 3'd5, 3'd6, 3'd0,
		3'd4, 3'd2, 3'd5, 3'd3
	};

	typedef enum logic [1:0] {
		waitFirst,
		waitSecond,
		finished
	} turnState;

endpackage

`default_nettype wire

/* boardIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface boardIf import memoryPkg::*; ();

	logic [coordWidth-1:0] peekX;
	logic [coordWidth-1:0] peekY;
	logic [valueWidth-1:0] peekValue; // Combinational from peekX and peekY.
	logic peekFaceUp;
	logic flip;
	logic [coordWidth-1:0] flipX;
	logic [coordWidth-1:0] flipY;
	logic hide;
	logic [coordWidth-1:0] hideX;
	logic [coordWidth-1:0] hideY;

	modport board (
		input peekX, peekY, flip, flipX, flipY, hide, hideX, hideY,
		output peekValue, peekFaceUp
	);

	modport looker (
		output peekX, peekY,
		input peekValue, peekFaceUp
	);

	modport controller (
		output flip, flipX, flipY, hide, hideX, hideY
	);

endinterface

interface pickIf import memoryPkg::*; ();

	logic selValid; // Single-cycle strobe per accepted pick.
	logic [coordWidth-1:0] selX;
	logic [coordWidth-1:0] selY;
	logic [valueWidth-1:0] selValue;

	modport source (
		output selValid, selX, selY, selValue
	);

	modport sink (
		input selValid, selX, selY, selValue
	);

endinterface

`default_nettype wire

/* pickCapture.sv */
`timescale 1ns/1ps
`default_nettype none

module pickCapture import memoryPkg::*; (
	input wire logic btnSelect,
	input wire logic rst,
	input wire logic pick,
	input wire logic [coordWidth-1:0] posX,
	input wire logic [coordWidth-1:0] posY,
	input wire logic gameOver,
	boardIf.looker board,
	pickIf.source sel,
	output logic rejected
);

	logic repeatPick;
	logic legal;

	assign board.peekX = posX; // The board answers in the same cycle.
	assign board.peekY = posY;

	// The flip for the pending selection only lands at this edge, so its
	// face-up flag still reads low and has to be caught here.
	assign repeatPick = sel.selValid && (sel.selX == posX) && (sel.selY == posY);

	assign legal = !board.peekFaceUp && !repeatPick && !gameOver;

	always_ff @(posedge btnSelect, posedge rst) begin
		if (rst) begin
			sel.selValid <= 1'b0;
			rejected <= 1'b0;
		end else begin
			sel.selValid <= pick && legal;
			rejected <= pick && !legal; // High for one cycle per refusal.
		end
	end

	always_ff @(posedge btnSelect) begin
		if (pick && legal) begin
			sel.selX <= posX;
			sel.selY <= posY;
			sel.selValue <= board.peekValue;
		end
	end

	// Every card is face up once the last pair is found, so no selection follows the end.
	noPickAfterEnd: assert property (
		@(posedge btnSelect) disable iff (rst)
		!(gameOver && sel.selValid)
	);

endmodule

`default_nettype wire

/* cardBoard.sv */
`timescale 1ns/1ps
`default_nettype none

module cardBoard import memoryPkg::*; (
	input wire logic btnSelect,
	input wire logic rst,
	boardIf.board board
);

	logic [valueWidth-1:0] cardValue [boardSide][boardSide]; // Indexed as [row][column].
	logic faceUp [boardSide][boardSide];

	always_ff @(posedge btnSelect, posedge rst) begin
		if (rst) begin
			for (int y = 0; y < boardSide; y++) begin
				for (int x = 0; x < boardSide; x++) begin
					cardValue[y][x] <= cardLayout[y*boardSide+x];
					faceUp[y][x] <= 1'b0;
				end
			end
		end else begin
			if (board.flip) begin
				faceUp[board.flipY][board.flipX] <= 1'b1;
			end
			if (board.hide) begin
				faceUp[board.hideY][board.hideX] <= 1'b0;
			end
		end
	end

	assign board.peekValue = cardValue[board.peekY][board.peekX];
	assign board.peekFaceUp = faceUp[board.peekY][board.peekX];

	// A card is never turned up and down at once; the judge owns both commands
	// and a clash would leave the flag depending on statement order.
	flipHideClash: assert property (
		@(posedge btnSelect) disable iff (rst)
		!(board.flip && board.hide && (board.flipX == board.hideX)
			&& (board.flipY == board.hideY))
	);

endmodule

`default_nettype wire

/* turnJudge.sv */
`timescale 1ns/1ps
`default_nettype none

module turnJudge import memoryPkg::*; (
	input wire logic btnSelect,
	input wire logic rst,
	pickIf.sink sel,
	boardIf.controller board,
	output logic match,
	output logic mismatch,
	output logic player,
	output logic [scoreWidth-1:0] scoreA,
	output logic [scoreWidth-1:0] scoreB,
	output logic gameOver
);

	turnState state;
	logic [coordWidth-1:0] firstX;
	logic [coordWidth-1:0] firstY;
	logic [valueWidth-1:0] firstValue;
	logic sameValue;
	logic [scoreWidth:0] pairsFound;
	logic lastPair;

	assign sameValue = (sel.selValue == firstValue);
	assign pairsFound = scoreA + scoreB; // Each found pair is worth one point.
	assign lastPair = (pairsFound == pairCount - 1);

	// Commands go out in the same cycle as the selection strobe.
	always_comb begin
		board.flip = 1'b0;
		board.hide = 1'b0;
		if (sel.selValid) begin
			case (state)
				waitFirst: board.flip = 1'b1;
				waitSecond: begin
					board.flip = sameValue;
					board.hide = !sameValue; // Second card never went face up.
				end
				default: ;
			endcase
		end
	end

	assign board.flipX = sel.selX;
	assign board.flipY = sel.selY;
	assign board.hideX = firstX;
	assign board.hideY = firstY;

	always_ff @(posedge btnSelect, posedge rst) begin
		if (rst) begin
			state <= waitFirst;
			match <= 1'b0;
			mismatch <= 1'b0;
			player <= 1'b0;
			scoreA <= '0;
			scoreB <= '0;
		end else begin
			match <= 1'b0;
			mismatch <= 1'b0;
			if (sel.selValid) begin
				case (state)
					waitFirst: state <= waitSecond;
					waitSecond: begin
						if (sameValue) begin
							match <= 1'b1;
							if (player) begin
								scoreB <= scoreB + 1'b1;
							end else begin
								scoreA <= scoreA + 1'b1;
							end
							state <= lastPair ? finished : waitFirst; // Player keeps the turn.
						end else begin
							mismatch <= 1'b1;
							player <= !player;
							state <= waitFirst;
						end
					end
					default: state <= finished;
				endcase
			end
		end
	end

	always_ff @(posedge btnSelect) begin
		if (sel.selValid && (state == waitFirst)) begin
			firstX <= sel.selX;
			firstY <= sel.selY;
			firstValue <= sel.selValue;
		end
	end

	assign gameOver = (state == finished);

	// The judge never compares a card with itself. That holds only if the
	// capture stage refuses both face-up cards and the pending selection.
	noSelfCompare: assert property (
		@(posedge btnSelect) disable iff (rst)
		!(sel.selValid && (state == waitSecond) && (sel.selX == firstX)
			&& (sel.selY == firstY))
	);

endmodule

`default_nettype wire

/* memoryGameTop.sv */
`timescale 1ns/1ps
`default_nettype none

module memoryGameTop import memoryPkg::*; (
	input wire logic btnSelect,
	input wire logic rst,
	input wire logic pick,
	input wire logic [coordWidth-1:0] posX,
	input wire logic [coordWidth-1:0] posY,
	output logic rejected,
	output logic match,
	output logic mismatch,
	output logic player,
	output logic [scoreWidth-1:0] scoreA,
	output logic [scoreWidth-1:0] scoreB,
	output logic gameOver
);

	boardIf boardBus ();
	pickIf pickBus ();

	pickCapture capture (
		.btnSelect(btnSelect),
		.rst(rst),
		.pick(pick),
		.posX(posX),
		.posY(posY),
		.gameOver(gameOver), // Fed back so the finished game refuses picks.
		.board(boardBus.looker),
		.sel(pickBus.source),
		.rejected(rejected)
	);

	cardBoard board (
		.btnSelect(btnSelect),
		.rst(rst),
		.board(boardBus.board)
	);

	turnJudge judge (
		.btnSelect(btnSelect),
		.rst(rst),
		.sel(pickBus.sink),
		.board(boardBus.controller),
		.match(match),
		.mismatch(mismatch),
		.player(player),
		.scoreA(scoreA),
		.scoreB(scoreB),
		.gameOver(gameOver)
	);

endmodule

`default_nettype wire

/* memoryGameTb.sv */
`timescale 1ns/1ps
`default_nettype none

module memoryGameTb import memoryPkg::*; ();

	localparam int halfPeriod = 20;
	localparam int resetCycles = 16;
	localparam int levelTimeout = 4 * halfPeriod; // Polling steps allowed per clock level.
	localparam int maxGap = 3; // Idle cycles after a pick range from 0 to maxGap - 1.

	logic btnSelect;
	logic rst;
	logic pick;
	logic [coordWidth-1:0] posX;
	logic [coordWidth-1:0] posY;
	logic rejected;
	logic match;
	logic mismatch;
	logic player;
	logic [scoreWidth-1:0] scoreA;
	logic [scoreWidth-1:0] scoreB;
	logic gameOver;

	int errorCount;
	int caseCount;
	bit timedOut;

	memoryGameTop uut (
		.btnSelect(btnSelect),
		.rst(rst),
		.pick(pick),
		.posX(posX),
		.posY(posY),
		.rejected(rejected),
		.match(match),
		.mismatch(mismatch),
		.player(player),
		.scoreA(scoreA),
		.scoreB(scoreB),
		.gameOver(gameOver)
	);

	always #halfPeriod btnSelect = ~btnSelect;

	task automatic waitLevel(input logic level);
		int steps;
		steps = 0;
		while (!timedOut && btnSelect !== level && steps < levelTimeout) begin
			#1;
			steps++;
		end
		if (!timedOut && btnSelect !== level) begin
			timedOut = 1'b1;
			errorCount++;
			$display("Timeout at time %0d ns: the clock did not reach level %b.", $time, level);
		end
	endtask

	task automatic nextRise();
		waitLevel(1'b0);
		waitLevel(1'b1);
	endtask

	// Outputs have long settled by the falling edge.
	task automatic nextFall();
		waitLevel(1'b1);
		waitLevel(1'b0);
	endtask

	task automatic reportWrong(input int caseIndex, input string name, input int actual,
			input int expected);
		errorCount++;
		$display("FAIL at time %0d ns: case %0d, %s is %0h but %0h was expected.",
			$time, caseIndex, name, actual, expected);
	endtask

	task automatic checkIdle();
		if (rejected !== 1'b0) begin
			reportWrong(0, "rejected", rejected, 0);
		end
		if (match !== 1'b0) begin
			reportWrong(0, "match", match, 0);
		end
		if (mismatch !== 1'b0) begin
			reportWrong(0, "mismatch", mismatch, 0);
		end
		if (player !== 1'b0) begin
			reportWrong(0, "player", player, 0);
		end
		if (scoreA !== '0) begin
			reportWrong(0, "scoreA", scoreA, 0);
		end
		if (scoreB !== '0) begin
			reportWrong(0, "scoreB", scoreB, 0);
		end
		if (gameOver !== 1'b0) begin
			reportWrong(0, "gameOver", gameOver, 0);
		end
	endtask

	task automatic playPick(
		input int caseIndex,
		input logic [coordWidth-1:0] x,
		input logic [coordWidth-1:0] y,
		input logic expRejected,
		input logic expMatch,
		input logic expMismatch,
		input logic expPlayer,
		input logic [scoreWidth-1:0] expScoreA,
		input logic [scoreWidth-1:0] expScoreB,
		input logic expGameOver
	);
		nextRise();
		pick <= 1'b1;
		posX <= x;
		posY <= y;
		nextRise(); // Pick stays high, so the same card is tried again at the next edge.
		nextFall();
		if (!timedOut && rejected !== expRejected) begin
			reportWrong(caseIndex, "rejected", rejected, expRejected);
		end
		nextRise();
		pick <= 1'b0;
		nextFall();
		if (!timedOut && rejected !== 1'b1) begin // A card picked one step earlier is refused.
			reportWrong(caseIndex, "rejected on the repeat", rejected, 1);
		end
		if (!timedOut && match !== expMatch) begin
			reportWrong(caseIndex, "match", match, expMatch);
		end
		if (!timedOut && mismatch !== expMismatch) begin
			reportWrong(caseIndex, "mismatch", mismatch, expMismatch);
		end
		if (!timedOut && player !== expPlayer) begin
			reportWrong(caseIndex, "player", player, expPlayer);
		end
		if (!timedOut && scoreA !== expScoreA) begin
			reportWrong(caseIndex, "scoreA", scoreA, expScoreA);
		end
		if (!timedOut && scoreB !== expScoreB) begin
			reportWrong(caseIndex, "scoreB", scoreB, expScoreB);
		end
		if (!timedOut && gameOver !== expGameOver) begin
			reportWrong(caseIndex, "gameOver", gameOver, expGameOver);
		end
	endtask

	task automatic runCases();
		int fd;
		int fields;
		int gap;
		string lineText;
		logic [coordWidth-1:0] x;
		logic [coordWidth-1:0] y;
		logic expRejected;
		logic expMatch;
		logic expMismatch;
		logic expPlayer;
		logic [scoreWidth-1:0] expScoreA;
		logic [scoreWidth-1:0] expScoreB;
		logic expGameOver;
		fd = $fopen("memoryGameCases.txt", "r");
		if (fd == 0) begin
			errorCount++;
			$display("Could not open memoryGameCases.txt for reading.");
		end else begin
			while (!timedOut && $fgets(lineText, fd) != 0) begin
				fields = $sscanf(lineText, "%h %h %h %h %h %h %h %h %h", x, y, expRejected,
					expMatch, expMismatch, expPlayer, expScoreA, expScoreB, expGameOver);
				if (fields == 9) begin // Comment and blank lines give fewer fields.
					caseCount++;
					playPick(caseCount, x, y, expRejected, expMatch, expMismatch, expPlayer,
						expScoreA, expScoreB, expGameOver);
					gap = $urandom % maxGap;
					repeat (gap) nextRise();
				end
			end
			$fclose(fd);
			if (caseCount == 0) begin
				errorCount++;
				$display("The cases file holds no pick lines.");
			end
		end
	endtask

	initial begin
		btnSelect = 1'b0;
		rst = 1'b1;
		pick = 1'b0;
		posX = '0;
		posY = '0;
		errorCount = 0;
		caseCount = 0;
		timedOut = 1'b0;
		void'($urandom(32'h9cdc));
		repeat (resetCycles) nextRise();
		rst <= 1'b0;
		nextFall();
		if (!timedOut) begin
			checkIdle();
		end
		runCases();
		$display("Cases run: %0d, errors: %0d", caseCount, errorCount);
		if (errorCount == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* memoryGameCases.txt */
// posX posY rejected match mismatch player scoreA scoreB gameOver
// All fields are hex. The expected outputs belong to the pick on the same line.
// Player 0 finds the pair of zeros, then both cards are refused.
0 0 0 0 0 0 0 0 0
3 2 0 1 0 0 1 0 0
0 0 1 0 0 0 1 0 0
3 2 1 0 0 0 1 0 0
// A repeated first card is refused, then a mismatch hands the turn over.
1 0 0 0 0 0 1 0 0
1 0 1 0 0 0 1 0 0
2 0 0 0 1 1 1 0 0
// The hidden first card can be picked again.
1 0 0 0 0 1 1 0 0
3 3 0 1 0 1 1 1 0
2 0 0 0 0 1 1 1 0
0 0 1 0 0 1 1 1 0
3 1 0 1 0 1 1 2 0
3 0 0 0 0 1 1 2 0
1 1 0 0 1 0 1 2 0
3 0 0 0 0 0 1 2 0
1 3 0 1 0 0 2 2 0
1 1 0 0 0 0 2 2 0
0 3 0 1 0 0 3 2 0
2 1 0 0 0 0 3 2 0
1 2 0 0 1 1 3 2 0
// The second card of a mismatch never went face up.
1 2 0 0 0 1 3 2 0
2 3 0 1 0 1 3 3 0
2 1 0 0 0 1 3 3 0
0 2 0 1 0 1 3 4 0
0 1 0 0 0 1 3 4 0
2 2 0 1 0 1 3 5 1
// The game is over and every further pick is refused.
2 2 1 0 0 1 3 5 1
0 0 1 0 0 1 3 5 1
3 3 1 0 0 1 3 5 1
1 1 1 0 0 1 3 5 1
2 0 1 0 0 1 3 5 1
0 3 1 0 0 1 3 5 1

/* sources.f */
memoryPkg.sv
boardIf.sv
pickCapture.sv
cardBoard.sv
turnJudge.sv
memoryGameTop.sv
memoryGameTb.sv

/* runSim.sh */
#!/usr/bin/env bash
# Builds the memory game testbench with Verilator, runs it and checks the result.

set -u

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
	echo "verilator was not found on the PATH"
	exit 1
fi

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module memoryGameTb --Mdir obj_dir -f sources.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "Compilation failed with status $status"
	exit 1
fi

output=$(./obj_dir/VmemoryGameTb)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "Verification passed" <<< "$output"; then
	exit 0
fi
exit 1
